//--- Makefile
VERILATOR ?= verilator
TOP       ?= smpc_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(shell grep -v '^+' $(FLIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test: $(SIM_BIN)
	./$(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/smpc_tb.sv
`timescale 1ns/1ps

module smpc_tb import smpc_pkg::*; ();

	localparam int unsigned TB_TICKS   = 1000;
	localparam int unsigned CLK_PERIOD = 10;
	localparam int unsigned CMD_BUDGET = 30;     // Commands the run may issue
	localparam int unsigned CMD_CYCLES = 1100;   // Longest command with its SF polling
	localparam int unsigned SEC_BUDGET = 7;      // Simulated seconds of plain waiting
	localparam int unsigned POLL_LIMIT = CMD_CYCLES;
	localparam longint unsigned WATCHDOG_NS =
		longint'(CMD_BUDGET * CMD_CYCLES + SEC_BUDGET * TB_TICKS) * CLK_PERIOD;

	logic         CLK;
	logic         RST_N;
	host_req_t    host_req;
	byte_t        rdata;
	reset_lines_t rst_lines;
	logic         mirq_n;

	reset_lines_t exp_lines = '0;
	logic [31:0]  rng_state = 32'hbf07;
	int unsigned  mirq_lows = 0;
	int unsigned  nmi_lows  = 0;

	smpc_top #(
		.TICKS_PER_SEC (TB_TICKS)
	) u_dut (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.host_req  (host_req),
		.rdata     (rdata),
		.rst_lines (rst_lines),
		.mirq_n    (mirq_n)
	);

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	always @(posedge CLK) begin
		if (!mirq_n)
			mirq_lows <= mirq_lows + 1;
		if (!rst_lines.mshnmi_n)
			nmi_lows <= nmi_lows + 1;
	end

	task automatic abort_run(input string msg);
		$display("Test FAILED");
		$fatal(1, "%s", msg);
	endtask

	task automatic value_error(input string msg);
		$display("error %0t: %s", $time, msg);
		abort_run(msg);
	endtask

	mirq_single: assert property (@(posedge CLK) disable iff (!RST_N) !mirq_n |=> mirq_n)
		else value_error("mirq_n low for two cycles in a row");

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic reg_addr_t oreg_addr(input int unsigned idx);
		return ADDR_OREG0 + reg_addr_t'(idx);
	endfunction

	// Reset line model after a power command
	function automatic reset_lines_t next_lines(input reset_lines_t l, input cmd_t code);
		reset_lines_t n;
		n = l;
		case (code)
			CMD_MSHON: begin
				n.mshres_n = 1'b1;
				n.mshnmi_n = 1'b1;
			end
			CMD_SSHON: begin
				n.sshres_n = 1'b1;
				n.sshnmi_n = 1'b1;
			end
			CMD_SSHOFF: begin
				n.sshres_n = 1'b0;
				n.sshnmi_n = 1'b1;
			end
			CMD_SNDON:  n.sndres_n = 1'b1;
			CMD_SNDOFF: n.sndres_n = 1'b0;
			CMD_CDON:   n.cdres_n = 1'b1;
			CMD_CDOFF:  n.cdres_n = 1'b0;
			default: ;
		endcase
		return n;
	endfunction

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		assert (got === exp)
			else value_error($sformatf("%s read %02h, expected %02h", what, got, exp));
	endtask

	task automatic write_reg(input reg_addr_t addr, input byte_t data);
		@(posedge CLK);
		host_req <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		@(posedge CLK);
		host_req <= '0;
	endtask

	task automatic read_reg(input reg_addr_t addr, output byte_t data);
		@(posedge CLK);
		host_req <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 8'h00};
		@(posedge CLK);
		host_req <= '0;
		@(negedge CLK);   // rdata settled after the capture edge
		data = rdata;
	endtask

	task automatic check_reg(input string what, input reg_addr_t addr, input byte_t exp);
		byte_t got;
		read_reg(addr, got);
		check_byte(what, got, exp);
	endtask

	task automatic run_cmd(input cmd_t code);
		byte_t       sf_val;
		int unsigned polls;
		write_reg(ADDR_SF, 8'h01);
		write_reg(ADDR_COMREG, code);
		polls  = 0;
		sf_val = 8'h01;
		while (sf_val != 8'h00) begin
			if (polls == POLL_LIMIT)
				abort_run($sformatf("command %02h never cleared SF", code));
			read_reg(ADDR_SF, sf_val);
			polls++;
		end
	endtask

	task automatic power_cmd(input cmd_t code);
		run_cmd(code);
		exp_lines = next_lines(exp_lines, code);
		assert (rst_lines === exp_lines)
			else value_error($sformatf("rst_lines %b after command %02h, expected %b",
				rst_lines, code, exp_lines));
		check_reg("OREG31", oreg_addr(31), code);
	endtask

	task automatic load_time(input logic [15:0] year, input byte_t dow_month, input bcd_t days,
			input bcd_t hour, input bcd_t mins, input bcd_t sec);
		write_reg(ADDR_IREG0, year[15:8]);
		write_reg(ADDR_IREG0 + 6'd1, year[7:0]);
		write_reg(ADDR_IREG0 + 6'd2, dow_month);
		write_reg(ADDR_IREG0 + 6'd3, days);
		write_reg(ADDR_IREG0 + 6'd4, hour);
		write_reg(ADDR_IREG0 + 6'd5, mins);
		write_reg(ADDR_IREG0 + 6'd6, sec);
		run_cmd(CMD_SETTIME);
	endtask

	task automatic status_intback();
		write_reg(ADDR_IREG0, 8'h01);
		write_reg(ADDR_IREG0 + 6'd2, INTBACK_KEY);
		run_cmd(CMD_INTBACK);
	endtask

	task automatic check_time(input logic [15:0] year, input byte_t dow_month, input bcd_t days,
			input bcd_t hour, input bcd_t mins, input bcd_t sec_lo, input bcd_t sec_hi);
		byte_t sec;
		check_reg("OREG1 year high", oreg_addr(1), year[15:8]);
		check_reg("OREG2 year low", oreg_addr(2), year[7:0]);
		check_reg("OREG3 day/month", oreg_addr(3), dow_month);
		check_reg("OREG4 days", oreg_addr(4), days);
		check_reg("OREG5 hour", oreg_addr(5), hour);
		check_reg("OREG6 min", oreg_addr(6), mins);
		read_reg(oreg_addr(7), sec);
		assert (sec >= sec_lo && sec <= sec_hi)
			else value_error($sformatf("OREG7 sec read %02h, expected %02h..%02h",
				sec, sec_lo, sec_hi));
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("watchdog expired after %0d ns, the run did not finish",
			WATCHDOG_NS));
	end

	initial begin
		byte_t       smem_exp [4];
		byte_t       ireg1_val;
		byte_t       oreg7_old;
		int unsigned mirq_before;
		int unsigned nmi_before;
		host_req = '0;
		RST_N    = 1'b0;
		repeat (2) @(posedge CLK);
		RST_N <= 1'b1;
		@(negedge CLK);

		// Test 1: reset values
		assert (rst_lines === '0)
			else value_error($sformatf("rst_lines %b after reset, expected 0", rst_lines));
		assert (mirq_n === 1'b1)
			else value_error("mirq_n not high after reset");
		check_reg("SF after reset", ADDR_SF, 8'h00);
		check_reg("SR after reset", ADDR_SR, 8'h00);

		// Test 2: power commands
		power_cmd(CMD_MSHON);
		power_cmd(CMD_SSHON);
		power_cmd(CMD_SSHOFF);
		power_cmd(CMD_SSHON);
		power_cmd(CMD_SNDON);
		power_cmd(CMD_SNDOFF);
		power_cmd(CMD_SNDON);
		power_cmd(CMD_CDON);
		power_cmd(CMD_CDOFF);
		power_cmd(CMD_CDON);

		// Test 3: NMI request pulse
		nmi_before = nmi_lows;
		run_cmd(CMD_NMIREQ);
		assert (nmi_lows > nmi_before)
			else value_error("mshnmi_n never went low during NMIREQ");
		assert (rst_lines.mshnmi_n === 1'b1)
			else value_error("mshnmi_n still low after NMIREQ");
		check_reg("OREG31 after NMIREQ", oreg_addr(31), CMD_NMIREQ);

		// Test 4: SMEM, RESD, time and status readout
		for (int i = 0; i < 4; i++) begin
			rng_state   = xorshift32(rng_state);
			smem_exp[i] = rng_state[7:0];
			write_reg(ADDR_IREG0 + reg_addr_t'(i), smem_exp[i]);
		end
		run_cmd(CMD_SETSMEM);
		run_cmd(CMD_RESENAB);
		load_time(16'h2031, 8'h37, 8'h15, 8'h10, 8'h20, 8'h30);
		rng_state = xorshift32(rng_state);
		ireg1_val = rng_state[7:0];
		write_reg(ADDR_IREG0 + 6'd1, ireg1_val);
		mirq_before = mirq_lows;
		status_intback();
		assert (mirq_lows == mirq_before + 1)
			else value_error($sformatf("mirq_n low %0d cycles, expected 1",
				mirq_lows - mirq_before));
		check_reg("OREG0 STE/RESD", oreg_addr(0), 8'h80);
		check_time(16'h2031, 8'h37, 8'h15, 8'h10, 8'h20, 8'h30, 8'h31);
		check_reg("OREG8", oreg_addr(8), 8'h00);
		check_reg("OREG9", oreg_addr(9), 8'h00);
		check_reg("OREG10", oreg_addr(10), 8'h34 | (exp_lines.mshnmi_n ? 8'h00 : 8'h08)
			| (exp_lines.sndres_n ? 8'h00 : 8'h01));
		check_reg("OREG11", oreg_addr(11), exp_lines.cdres_n ? 8'h00 : 8'h40);
		for (int i = 0; i < 4; i++)
			check_reg($sformatf("OREG%0d SMEM", 12 + i), oreg_addr(12 + i), smem_exp[i]);
		check_reg("OREG31 after INTBACK", oreg_addr(31), CMD_INTBACK);
		check_reg("SR after INTBACK", ADDR_SR, {2'b01, 2'b00, ireg1_val[7:4]});

		// Test 5: month and year rollover
		load_time(16'h2025, 8'h52, 8'h28, 8'h23, 8'h59, 8'h59);
		repeat (2000) @(posedge CLK);
		status_intback();
		check_time(16'h2025, 8'h53, 8'h01, 8'h00, 8'h00, 8'h01, 8'h02);
		load_time(16'h2025, 8'h3C, 8'h31, 8'h23, 8'h59, 8'h59);
		repeat (2000) @(posedge CLK);
		status_intback();
		check_time(16'h2026, 8'h31, 8'h01, 8'h00, 8'h00, 8'h01, 8'h02);

		// Test 6: INTBACK with a bad key
		run_cmd(CMD_RESDISA);
		read_reg(oreg_addr(7), oreg7_old);
		write_reg(ADDR_IREG0, 8'h01);
		write_reg(ADDR_IREG0 + 6'd2, 8'h00);
		mirq_before = mirq_lows;
		run_cmd(CMD_INTBACK);
		assert (mirq_lows == mirq_before)
			else value_error("mirq_n pulsed on an INTBACK with a bad key");
		check_reg("OREG7 after bad INTBACK", oreg_addr(7), oreg7_old);
		check_reg("OREG31 after bad INTBACK", oreg_addr(31), CMD_RESDISA);

		$display("Test OK");
		$finish;
	end

endmodule

//--- flist.f
hdl/smpc_pkg.sv
hdl/smpc_oreg_ram.sv
hdl/smpc_rtc.sv
hdl/smpc_cmd_seq.sv
hdl/smpc_host_regs.sv
hdl/smpc_top.sv
dv/smpc_tb.sv

//--- hdl/smpc_cmd_seq.sv
`timescale 1ns/1ps

module smpc_cmd_seq import smpc_pkg::*; (
	input  logic         CLK,
	input  logic         RST_N,
	input  cmd_t         comreg,
	input  logic         cmd_pending,
	output logic         cmd_take,
	output logic         sf_clear,
	input  ireg_file_t   ireg,
	input  rtc_time_t    now,
	output logic         time_load,
	output oreg_wr_t     oreg_wr,
	output logic         status_done,
	output reset_lines_t rst_lines,
	output logic         mirq_n
);

	seq_state_t state;
	seq_state_t next_state;
	wait_cnt_t  wait_cnt;
	oreg_addr_t oreg_cnt;
	logic       resd;
	logic       ste;
	byte_t      smem [4];
	byte_t      status_byte;
	logic       is_intback;
	logic       intback_ok;

	assign is_intback = (comreg == CMD_INTBACK);
	assign intback_ok = (ireg[2] == INTBACK_KEY) && ireg[0][0];   // Status form only
	assign cmd_take   = (state == IDLE) && cmd_pending;
	assign sf_clear   = (state == END);
	assign time_load  = (state == EXEC) && (comreg == CMD_SETTIME);

	always_comb begin
		status_byte = 8'h00;
		if (oreg_cnt == OREG_LAST) begin
			status_byte = comreg;
		end else if (oreg_cnt < STATUS_BYTES) begin
			case (oreg_cnt)
				5'd0:  status_byte = {ste, resd, 6'b000000};
				5'd1:  status_byte = now.year[15:8];
				5'd2:  status_byte = now.year[7:0];
				5'd3:  status_byte = {now.day_of_week, now.month};
				5'd4:  status_byte = now.days;
				5'd5:  status_byte = now.hour;
				5'd6:  status_byte = now.min;
				5'd7:  status_byte = now.sec;
				5'd10: status_byte = {2'b00, 2'b11, ~rst_lines.mshnmi_n, 1'b1, 1'b0,
					~rst_lines.sndres_n};
				5'd11: status_byte = {1'b0, ~rst_lines.cdres_n, 6'b000000};
				5'd12, 5'd13, 5'd14, 5'd15: status_byte = smem[oreg_cnt[1:0]];
				default: status_byte = 8'h00;   // Area code and reserved bytes
			endcase
		end
	end

	// Plain commands only log COMREG into OREG31
	always_comb begin
		oreg_wr.we   = (state == EXEC);
		oreg_wr.addr = is_intback ? oreg_cnt : OREG_LAST;
		oreg_wr.data = is_intback ? status_byte : comreg;
	end

	always_ff @(posedge CLK) begin
		if (state == EXEC && comreg == CMD_SETSMEM) begin
			smem[0] <= ireg[0];
			smem[1] <= ireg[1];
			smem[2] <= ireg[2];
			smem[3] <= ireg[3];
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state       <= IDLE;
			next_state  <= IDLE;
			wait_cnt    <= '0;
			oreg_cnt    <= '0;
			resd        <= 1'b1;
			ste         <= 1'b0;
			status_done <= 1'b0;
			rst_lines   <= '0;
			mirq_n      <= 1'b1;
		end else begin
			mirq_n <= 1'b1;
			case (state)
				IDLE: begin
					if (cmd_pending) begin
						wait_cnt   <= WAIT_ISSUE;
						next_state <= COMMAND;
						state      <= WAIT;
					end
				end
				WAIT: begin
					if (wait_cnt == '0)
						state <= next_state;
					else
						wait_cnt <= wait_cnt - wait_cnt_t'(1);
				end
				COMMAND: begin
					next_state <= EXEC;
					state      <= WAIT;
					oreg_cnt   <= '0;
					case (comreg)
						CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF:
							wait_cnt <= WAIT_POWER;
						CMD_CDON, CMD_CDOFF:                 wait_cnt <= WAIT_CD;
						CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA: wait_cnt <= WAIT_NMI;
						CMD_SETTIME:                          wait_cnt <= WAIT_SETTIME;
						CMD_SETSMEM:                          wait_cnt <= WAIT_SETSMEM;
						CMD_INTBACK: begin
							if (intback_ok)
								wait_cnt <= WAIT_INTBACK;
							else
								state <= END;   // Bad keys, nothing written
						end
						default: state <= EXEC;
					endcase
				end
				EXEC: begin
					state <= END;
					case (comreg)
						CMD_MSHON: begin
							rst_lines.mshres_n <= 1'b1;
							rst_lines.mshnmi_n <= 1'b1;
						end
						CMD_SSHON: begin
							rst_lines.sshres_n <= 1'b1;
							rst_lines.sshnmi_n <= 1'b1;
						end
						CMD_SSHOFF: begin
							rst_lines.sshres_n <= 1'b0;
							rst_lines.sshnmi_n <= 1'b1;
						end
						CMD_SNDON:   rst_lines.sndres_n <= 1'b1;
						CMD_SNDOFF:  rst_lines.sndres_n <= 1'b0;
						CMD_CDON:    rst_lines.cdres_n <= 1'b1;
						CMD_CDOFF:   rst_lines.cdres_n <= 1'b0;
						CMD_NMIREQ:  rst_lines.mshnmi_n <= 1'b0;
						CMD_RESENAB: resd <= 1'b0;
						CMD_RESDISA: resd <= 1'b1;
						CMD_SETTIME: ste <= 1'b1;
						CMD_INTBACK: begin
							oreg_cnt <= oreg_cnt + 5'd1;
							if (oreg_cnt == OREG_LAST) begin
								status_done <= 1'b1;
								mirq_n      <= 1'b0;   // Low through END only
							end else begin
								state <= EXEC;
							end
						end
						default: ;
					endcase
				end
				END: begin
					if (comreg == CMD_NMIREQ)
						rst_lines.mshnmi_n <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- hdl/smpc_host_regs.sv
`timescale 1ns/1ps

module smpc_host_regs import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  host_req_t  host_req,
	output byte_t      rdata,
	output ireg_file_t ireg,
	output cmd_t       comreg,
	output logic       cmd_pending,
	input  logic       cmd_take,
	input  logic       sf_clear,
	input  logic       status_done,
	output oreg_addr_t oreg_raddr,
	input  byte_t      oreg_rdata
);

	reg_addr_t ireg_idx;
	reg_addr_t oreg_off;
	logic      in_oreg;
	logic      sf;
	byte_t     sr;

	assign ireg_idx   = host_req.addr - ADDR_IREG0;
	assign oreg_off   = host_req.addr - ADDR_OREG0;
	assign oreg_raddr = oreg_off[4:0];
	assign in_oreg    = (host_req.addr >= ADDR_OREG0) && (host_req.addr < ADDR_SR);

	// Peripheral and SRES bits read as zero
	assign sr = {1'b0, status_done, 2'b00, ireg[1][7:4]};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ireg        <= '0;
			comreg      <= '0;
			cmd_pending <= 1'b0;
			sf          <= 1'b0;
		end else begin
			if (cmd_take)
				cmd_pending <= 1'b0;
			if (sf_clear)
				sf <= 1'b0;
			if (host_req.wr) begin                 // A new write wins over a clear
				if (ireg_idx < 6'd7)
					ireg[ireg_idx[2:0]] <= host_req.wdata;
				case (host_req.addr)
					ADDR_COMREG: begin
						comreg      <= host_req.wdata;
						cmd_pending <= 1'b1;
					end
					ADDR_SF: begin
						if (host_req.wdata[0])
							sf <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdata <= '0;
		end else if (host_req.rd) begin
			if (in_oreg) begin
				rdata <= oreg_rdata;
			end else begin
				case (host_req.addr)
					ADDR_SR: rdata <= sr;
					ADDR_SF: rdata <= {7'b0000000, sf};
					default: rdata <= 8'h00;   // Unmapped
				endcase
			end
		end
	end

endmodule

//--- hdl/smpc_oreg_ram.sv
`timescale 1ns/1ps

module smpc_oreg_ram import smpc_pkg::*; (
	input  logic       CLK,
	input  oreg_wr_t   wr,
	input  oreg_addr_t raddr,
	output byte_t      rdata
);

	localparam int unsigned DEPTH = 1 << $bits(oreg_addr_t);

	byte_t mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (wr.we)
			mem[wr.addr] <= wr.data;
	end

	assign rdata = mem[raddr];   // Async read

endmodule

//--- hdl/smpc_pkg.sv
package smpc_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] bcd_t;
	typedef logic [5:0] reg_addr_t;   // Host word address A[6:1]
	typedef logic [4:0] oreg_addr_t;
	typedef logic [7:0] cmd_t;
	typedef logic [9:0] wait_cnt_t;

	typedef byte_t [6:0] ireg_file_t; // IREG0 in the low byte

	typedef struct packed {
		logic      wr;
		logic      rd;
		reg_addr_t addr;
		byte_t     wdata;
	} host_req_t;

	typedef struct packed {
		logic [15:0] year;            // Four BCD digits
		logic [3:0]  day_of_week;
		logic [3:0]  month;           // Binary 1..12
		bcd_t        days;
		bcd_t        hour;
		bcd_t        min;
		bcd_t        sec;
	} rtc_time_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sndres_n;
		logic cdres_n;
	} reset_lines_t;

	typedef struct packed {
		logic       we;
		oreg_addr_t addr;
		byte_t      data;
	} oreg_wr_t;

	typedef enum logic [2:0] {IDLE, WAIT, COMMAND, EXEC, END} seq_state_t;

	localparam cmd_t CMD_MSHON   = 8'h00;
	localparam cmd_t CMD_SSHON   = 8'h02;
	localparam cmd_t CMD_SSHOFF  = 8'h03;
	localparam cmd_t CMD_SNDON   = 8'h06;
	localparam cmd_t CMD_SNDOFF  = 8'h07;
	localparam cmd_t CMD_CDON    = 8'h08;
	localparam cmd_t CMD_CDOFF   = 8'h09;
	localparam cmd_t CMD_INTBACK = 8'h10;
	localparam cmd_t CMD_SETTIME = 8'h16;
	localparam cmd_t CMD_SETSMEM = 8'h17;
	localparam cmd_t CMD_NMIREQ  = 8'h18;
	localparam cmd_t CMD_RESENAB = 8'h19;
	localparam cmd_t CMD_RESDISA = 8'h1A;

	localparam reg_addr_t ADDR_IREG0  = 6'h00;
	localparam reg_addr_t ADDR_COMREG = 6'h0F;
	localparam reg_addr_t ADDR_OREG0  = 6'h10;
	localparam reg_addr_t ADDR_SR     = 6'h30;
	localparam reg_addr_t ADDR_SF     = 6'h31;

	localparam wait_cnt_t WAIT_ISSUE   = 10'd90;
	localparam wait_cnt_t WAIT_POWER   = 10'd120;
	localparam wait_cnt_t WAIT_CD      = 10'd159;
	localparam wait_cnt_t WAIT_NMI     = 10'd127;
	localparam wait_cnt_t WAIT_SETTIME = 10'd279;
	localparam wait_cnt_t WAIT_SETSMEM = 10'd159;
	localparam wait_cnt_t WAIT_INTBACK = 10'd800;

	localparam byte_t      INTBACK_KEY  = 8'hF0;
	localparam oreg_addr_t OREG_LAST    = 5'd31;
	localparam oreg_addr_t STATUS_BYTES = 5'd16;

	localparam int unsigned RTC_TICKS_PER_SEC = 4000000;
	localparam rtc_time_t RTC_RESET_TIME = '{
		year:        16'h2024,
		day_of_week: 4'd0,
		month:       4'd1,
		days:        8'h01,
		hour:        8'h00,
		min:         8'h00,
		sec:         8'h00
	};

endpackage

//--- hdl/smpc_rtc.sv
`timescale 1ns/1ps

module smpc_rtc import smpc_pkg::*; #(
	parameter int unsigned TICKS_PER_SEC = RTC_TICKS_PER_SEC
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       time_load,
	input  ireg_file_t ireg,
	output rtc_time_t  now
);

	localparam int unsigned TICK_W = $clog2(TICKS_PER_SEC);

	logic [TICK_W-1:0] tick_cnt;
	logic              sec_tick;
	logic              min_carry;
	logic              hour_carry;
	logic              day_carry;
	logic              month_carry;
	logic              year_carry;
	bcd_t              last_day;

	function automatic bcd_t bcd_inc(input bcd_t v);
		bcd_t r;
		if (v[3:0] != 4'd9)
			r = {v[7:4], v[3:0] + 4'd1};
		else if (v[7:4] == 4'd9)
			r = 8'h00;
		else
			r = {v[7:4] + 4'd1, 4'd0};
		return r;
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tick_cnt <= '0;
			sec_tick <= 1'b0;
		end else begin
			sec_tick <= 1'b0;
			if (tick_cnt == TICK_W'(TICKS_PER_SEC - 1)) begin
				tick_cnt <= '0;
				sec_tick <= 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// February is always 28 days
	always_comb begin
		case (now.month)
			4'd2:                     last_day = 8'h28;
			4'd4, 4'd6, 4'd9, 4'd11: last_day = 8'h30;
			default:                  last_day = 8'h31;
		endcase
	end

	assign min_carry   = sec_tick && (now.sec == 8'h59);
	assign hour_carry  = min_carry && (now.min == 8'h59);
	assign day_carry   = hour_carry && (now.hour == 8'h23);
	assign month_carry = day_carry && (now.days == last_day);
	assign year_carry  = month_carry && (now.month == 4'd12);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			now <= RTC_RESET_TIME;
		end else if (time_load) begin
			now.sec                        <= ireg[6];
			now.min                        <= ireg[5];
			now.hour                       <= ireg[4];
			now.days                       <= ireg[3];
			{now.day_of_week, now.month} <= ireg[2];
			now.year                       <= {ireg[0], ireg[1]};
		end else begin
			if (sec_tick)
				now.sec <= min_carry ? 8'h00 : bcd_inc(now.sec);
			if (min_carry)
				now.min <= hour_carry ? 8'h00 : bcd_inc(now.min);
			if (hour_carry)
				now.hour <= day_carry ? 8'h00 : bcd_inc(now.hour);
			if (day_carry)
				now.days <= month_carry ? 8'h01 : bcd_inc(now.days);
			if (month_carry)
				now.month <= year_carry ? 4'd1 : now.month + 4'd1;
			if (year_carry) begin
				now.year[7:0] <= bcd_inc(now.year[7:0]);
				if (now.year[7:0] == 8'h99)
					now.year[15:8] <= bcd_inc(now.year[15:8]);   // Century digits
			end
		end
	end

endmodule

//--- hdl/smpc_top.sv
`timescale 1ns/1ps

module smpc_top import smpc_pkg::*; #(
	parameter int unsigned TICKS_PER_SEC = RTC_TICKS_PER_SEC
) (
	input  logic         CLK,
	input  logic         RST_N,
	input  host_req_t    host_req,
	output byte_t        rdata,
	output reset_lines_t rst_lines,
	output logic         mirq_n
);

	ireg_file_t ireg;
	cmd_t       comreg;
	logic       cmd_pending;
	logic       cmd_take;
	logic       sf_clear;
	logic       status_done;
	logic       time_load;
	rtc_time_t  now;
	oreg_wr_t   oreg_wr;
	oreg_addr_t oreg_raddr;
	byte_t      oreg_rdata;

	smpc_host_regs u_host_regs (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.host_req    (host_req),
		.rdata       (rdata),
		.ireg        (ireg),
		.comreg      (comreg),
		.cmd_pending (cmd_pending),
		.cmd_take    (cmd_take),
		.sf_clear    (sf_clear),
		.status_done (status_done),
		.oreg_raddr  (oreg_raddr),
		.oreg_rdata  (oreg_rdata)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.comreg      (comreg),
		.cmd_pending (cmd_pending),
		.cmd_take    (cmd_take),
		.sf_clear    (sf_clear),
		.ireg        (ireg),
		.now         (now),
		.time_load   (time_load),
		.oreg_wr     (oreg_wr),
		.status_done (status_done),
		.rst_lines   (rst_lines),
		.mirq_n      (mirq_n)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.time_load (time_load),
		.ireg      (ireg),
		.now       (now)
	);

	smpc_oreg_ram u_oreg (
		.CLK   (CLK),
		.wr    (oreg_wr),
		.raddr (oreg_raddr),
		.rdata (oreg_rdata)
	);

endmodule
